/* riscv_defines.svh */
// integer execute widths

`ifndef RISCV_DEFINES_SVH
`define RISCV_DEFINES_SVH

// ---------------------------------------------------
// datapath widths
// ---------------------------------------------------

// integer register and operand width
`define RV_XLEN 32

// register index width, 32 architectural registers
`define RV_REG_AW 5

`endif

/* riscv_pkg.sv */
// integer execute types

`include "riscv_defines.svh"

package riscv_pkg;

    // ---------------------------------------------------
    // vector types
    // ---------------------------------------------------
    typedef logic [`RV_XLEN-1:0]   xlen_t;
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;
    typedef logic [31:0]           instr_t;

    // alu operations, pass_b carries the lui immediate through
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    // major opcodes handled here
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // ---------------------------------------------------
    // pipeline structs
    // ---------------------------------------------------
    typedef struct packed {
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      rs1_rd;
        logic      rs2_rd;
        logic      use_imm;
        xlen_t     imm;
        alu_op_e   alu_op;
        logic      wr_en;
    } dec_s;

    // writeback stage
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        xlen_t     data;
    } wb_s;

    // load return strobe
    typedef struct packed {
        logic      wr;
        reg_addr_t rd;
        xlen_t     data;
    } ld_s;

endpackage

/* int_regs.sv */
// integer register file

`timescale 1ns/1ps

`include "riscv_defines.svh"

module int_regs (
    // global
    input  logic                 clk_i,
    input  logic                 clk_en_i,
    input  logic                 arst_n_i,
    // write ports, a from writeback and b from load return
    input  riscv_pkg::wb_s       wb_i,
    input  riscv_pkg::ld_s       ld_i,
    // read ports
    input  logic                 rs1_rd_i,
    input  logic                 rs2_rd_i,
    input  riscv_pkg::reg_addr_t rs1_addr_i,
    input  riscv_pkg::reg_addr_t rs2_addr_i,
    output riscv_pkg::xlen_t     rs1_data_o,
    output riscv_pkg::xlen_t     rs2_data_o
);

    localparam int NUM_REGS = 1 << `RV_REG_AW;

    // x0 has no storage
    riscv_pkg::xlen_t mem [1:NUM_REGS-1];

    // ---------------------------------------------------
    // write
    // ---------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                mem[i] <= '0;
            end
        end else if (clk_en_i) begin
            // port a, alu result
            if (wb_i.valid && wb_i.rd != '0) begin
                mem[wb_i.rd] <= wb_i.data;
            end
            // port b last so a load to the same register wins
            if (ld_i.wr && ld_i.rd != '0) begin
                mem[ld_i.rd] <= ld_i.data;
            end
        end
    end

    // ---------------------------------------------------
    // read
    // ---------------------------------------------------
    // zero for x0 or a disabled port
    function automatic riscv_pkg::xlen_t read_port(input logic en,
                                                   input riscv_pkg::reg_addr_t addr);
        if (en && addr != '0) begin
            return mem[addr];
        end
        return '0;
    endfunction

    assign rs1_data_o = read_port(rs1_rd_i, rs1_addr_i);
    assign rs2_data_o = read_port(rs2_rd_i, rs2_addr_i);

endmodule

/* exec_ctrl.sv */
// execute control and writeback

`timescale 1ns/1ps

module exec_ctrl (
    // global
    input  logic                 clk_i,
    input  logic                 clk_en_i,
    input  logic                 arst_n_i,
    // instruction in
    input  logic                 instr_valid_i,
    input  riscv_pkg::instr_t    instr_i,
    // alu result back from datapath
    input  riscv_pkg::xlen_t     alu_res_i,
    // decode and writeback out
    output riscv_pkg::dec_s      dec_o,
    output riscv_pkg::wb_s       wb_o,
    output logic                 illegal_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;

    logic                 wb_valid_q;
    riscv_pkg::reg_addr_t wb_rd_q;
    riscv_pkg::xlen_t     wb_data_q;
    logic                 illegal_q;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // funct3 to alu op, alt picks sub at 000 and sra at 101
    function automatic riscv_pkg::alu_op_e f3_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? riscv_pkg::ALU_SUB : riscv_pkg::ALU_ADD;
            3'b001:  return riscv_pkg::ALU_SLL;
            3'b010:  return riscv_pkg::ALU_SLT;
            3'b011:  return riscv_pkg::ALU_SLTU;
            3'b100:  return riscv_pkg::ALU_XOR;
            3'b101:  return alt ? riscv_pkg::ALU_SRA : riscv_pkg::ALU_SRL;
            3'b110:  return riscv_pkg::ALU_OR;
            default: return riscv_pkg::ALU_AND;
        endcase
    endfunction

    // ---------------------------------------------------
    // decode
    // ---------------------------------------------------
    always_comb begin
        dec_o         = '0;
        dec_o.rd      = instr_i[11:7];
        dec_o.rs1     = instr_i[19:15];
        dec_o.rs2     = instr_i[24:20];
        dec_o.alu_op  = riscv_pkg::ALU_ADD;
        legal         = 1'b0;
        case (opcode)
            riscv_pkg::OPC_OP: begin
                // only sub and sra take the alternate funct7
                legal = (funct7 == 7'b0000000) ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
                dec_o.rs1_rd = 1'b1;
                dec_o.rs2_rd = 1'b1;
                dec_o.alu_op = f3_op(funct3, funct7[5]);
            end
            riscv_pkg::OPC_OP_IMM: begin
                // shift immediates restrict the upper bits
                if (funct3 == 3'b001) begin
                    legal = (funct7 == 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end else begin
                    legal = 1'b1;
                end
                dec_o.rs1_rd  = 1'b1;
                dec_o.use_imm = 1'b1;
                dec_o.imm     = riscv_pkg::xlen_t'($signed(instr_i[31:20]));
                dec_o.alu_op  = f3_op(funct3, (funct3 == 3'b101) && funct7[5]);
            end
            riscv_pkg::OPC_LUI: begin
                legal         = 1'b1;
                dec_o.use_imm = 1'b1;
                dec_o.imm     = riscv_pkg::xlen_t'($signed({instr_i[31:12], 12'b0}));
                dec_o.alu_op  = riscv_pkg::ALU_PASS_B;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
        // idle cycles read nothing and write nothing
        dec_o.rs1_rd = dec_o.rs1_rd & instr_valid_i;
        dec_o.rs2_rd = dec_o.rs2_rd & instr_valid_i;
        dec_o.wr_en  = instr_valid_i & legal;
    end

    // ---------------------------------------------------
    // writeback register
    // ---------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_q <= 1'b0;
            illegal_q  <= 1'b0;
        end else if (clk_en_i) begin
            wb_valid_q <= dec_o.wr_en;
            illegal_q  <= instr_valid_i & ~legal;
        end
    end

    // result payload
    always_ff @(posedge clk_i) begin
        if (clk_en_i && dec_o.wr_en) begin
            wb_rd_q   <= dec_o.rd;
            wb_data_q <= alu_res_i;
        end
    end

    assign wb_o      = '{valid: wb_valid_q, rd: wb_rd_q, data: wb_data_q};
    assign illegal_o = illegal_q;

endmodule

/* operand_bypass.sv */
// operand forwarding

`timescale 1ns/1ps

module operand_bypass (
    input  riscv_pkg::dec_s  dec_i,
    // forwarding sources
    input  riscv_pkg::wb_s   wb_i,
    input  riscv_pkg::ld_s   ld_i,
    // register file values
    input  riscv_pkg::xlen_t rs1_data_i,
    input  riscv_pkg::xlen_t rs2_data_i,
    // alu operands
    output riscv_pkg::xlen_t op_a_o,
    output riscv_pkg::xlen_t op_b_o
);

    riscv_pkg::xlen_t rs2_val;

    // ---------------------------------------------------
    // forwarding select
    // ---------------------------------------------------
    // load this cycle, then writeback stage, then register file
    function automatic riscv_pkg::xlen_t fwd(input logic                 en,
                                             input riscv_pkg::reg_addr_t addr,
                                             input riscv_pkg::xlen_t     rf_data);
        if (!en || addr == '0) begin
            return '0;
        end
        if (ld_i.wr && ld_i.rd == addr) begin
            return ld_i.data;
        end
        if (wb_i.valid && wb_i.rd == addr) begin
            return wb_i.data;
        end
        return rf_data;
    endfunction

    assign op_a_o  = fwd(dec_i.rs1_rd, dec_i.rs1, rs1_data_i);
    assign rs2_val = fwd(dec_i.rs2_rd, dec_i.rs2, rs2_data_i);

    // immediate formats replace operand b
    assign op_b_o  = dec_i.use_imm ? dec_i.imm : rs2_val;

endmodule

/* int_alu.sv */
// integer alu

`timescale 1ns/1ps

`include "riscv_defines.svh"

module int_alu (
    input  riscv_pkg::alu_op_e op_i,
    input  riscv_pkg::xlen_t   a_i,
    input  riscv_pkg::xlen_t   b_i,
    output riscv_pkg::xlen_t   res_o
);

    localparam int SHAMT_W = $clog2(`RV_XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_s;
    logic               lt_u;

    // shift amount from low bits of b only
    assign shamt = b_i[SHAMT_W-1:0];

    // compares
    assign lt_s = $signed(a_i) < $signed(b_i);
    assign lt_u = a_i < b_i;

    // ---------------------------------------------------
    // result select
    // ---------------------------------------------------
    always_comb begin
        case (op_i)
            riscv_pkg::ALU_ADD: begin
                res_o = a_i + b_i;
            end
            riscv_pkg::ALU_SUB: begin
                res_o = a_i - b_i;
            end
            riscv_pkg::ALU_SLL: begin
                res_o = a_i << shamt;
            end
            riscv_pkg::ALU_SLT: begin
                res_o = riscv_pkg::xlen_t'(lt_s);
            end
            riscv_pkg::ALU_SLTU: begin
                res_o = riscv_pkg::xlen_t'(lt_u);
            end
            riscv_pkg::ALU_XOR: res_o = a_i ^ b_i;
            riscv_pkg::ALU_SRL: res_o = a_i >> shamt;
            // arithmetic shift keeps the sign
            riscv_pkg::ALU_SRA: res_o = riscv_pkg::xlen_t'($signed(a_i) >>> shamt);
            riscv_pkg::ALU_OR:  res_o = a_i | b_i;
            riscv_pkg::ALU_AND: res_o = a_i & b_i;
            // lui, immediate straight through
            riscv_pkg::ALU_PASS_B: res_o = b_i;
            default: begin
                res_o = '0;
            end
        endcase
    end

endmodule

/* int_exec_top.sv */
// integer execute subsystem

`timescale 1ns/1ps

module int_exec_top (
    // global
    input  logic                 clk_i,
    input  logic                 clk_en_i,
    input  logic                 arst_n_i,
    // instruction strobe
    input  logic                 instr_valid_i,
    input  riscv_pkg::instr_t    instr_i,
    // load return strobe
    input  logic                 ld_wr_i,
    input  riscv_pkg::reg_addr_t ld_rd_i,
    input  riscv_pkg::xlen_t     ld_data_i,
    // results
    output riscv_pkg::wb_s       result_o,
    output logic                 illegal_o
);

    riscv_pkg::dec_s  dec;
    riscv_pkg::wb_s   wb;
    riscv_pkg::ld_s   ld;
    riscv_pkg::xlen_t rs1_data;
    riscv_pkg::xlen_t rs2_data;
    riscv_pkg::xlen_t op_a;
    riscv_pkg::xlen_t op_b;
    riscv_pkg::xlen_t alu_res;

    // load return bundle
    assign ld       = '{wr: ld_wr_i, rd: ld_rd_i, data: ld_data_i};
    assign result_o = wb;

    // ---------------------------------------------------
    // control and datapath
    // ---------------------------------------------------
    exec_ctrl u_ctrl (
        .clk_i(clk_i), .clk_en_i(clk_en_i), .arst_n_i(arst_n_i),
        .instr_valid_i(instr_valid_i), .instr_i(instr_i), .alu_res_i(alu_res),
        .dec_o(dec), .wb_o(wb), .illegal_o(illegal_o)
    );

    int_regs u_regs (
        .clk_i(clk_i), .clk_en_i(clk_en_i), .arst_n_i(arst_n_i),
        .wb_i(wb), .ld_i(ld),
        .rs1_rd_i(dec.rs1_rd), .rs2_rd_i(dec.rs2_rd),
        .rs1_addr_i(dec.rs1), .rs2_addr_i(dec.rs2),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
    );

    operand_bypass u_bypass (
        .dec_i(dec), .wb_i(wb), .ld_i(ld),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .op_a_o(op_a), .op_b_o(op_b)
    );

    int_alu u_alu (.op_i(dec.alu_op), .a_i(op_a), .b_i(op_b), .res_o(alu_res));

endmodule

/* tb_int_exec.sv */
// integer execute testbench

`timescale 1ns/1ps

module tb_int_exec;

    localparam int TIMEOUT = 20;

    logic                 clk_i;
    logic                 clk_en_i;
    logic                 arst_n_i;
    logic                 instr_valid_i;
    riscv_pkg::instr_t    instr_i;
    logic                 ld_wr_i;
    riscv_pkg::reg_addr_t ld_rd_i;
    riscv_pkg::xlen_t     ld_data_i;
    riscv_pkg::wb_s       result;
    logic                 illegal_o;

    // reference registers and the next and current expected writeback
    riscv_pkg::xlen_t ref_regs [32];
    riscv_pkg::wb_s   nxt_wb;
    riscv_pkg::wb_s   exp_wb;
    logic             nxt_illegal;
    logic             exp_illegal;
    integer           seed = 62972;
    int               errors = 0;
    int               tests = 0;
    int               mark = 0;

    int_exec_top UUT (
        .clk_i(clk_i), .clk_en_i(clk_en_i), .arst_n_i(arst_n_i),
        .instr_valid_i(instr_valid_i), .instr_i(instr_i),
        .ld_wr_i(ld_wr_i), .ld_rd_i(ld_rd_i), .ld_data_i(ld_data_i),
        .result_o(result), .illegal_o(illegal_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // writeback stage model one cycle behind and frozen by clk_en_i
    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exp_wb      <= '0;
            exp_illegal <= 1'b0;
        end else if (clk_en_i) begin
            exp_wb.valid <= nxt_wb.valid;
            exp_illegal  <= nxt_illegal;
            if (nxt_wb.valid) begin
                exp_wb.rd   <= nxt_wb.rd;
                exp_wb.data <= nxt_wb.data;
            end
        end
    end

    // ---------------------------------------------------
    // checks at mid-cycle where outputs are settled
    // ---------------------------------------------------
    valid_chk: assert property (@(negedge clk_i) disable iff (!arst_n_i)
        result.valid == exp_wb.valid)
    else begin
        errors++;
        $display("Mismatch at %0t: result_o.valid expected %b got %b",
                 $time, exp_wb.valid, result.valid);
    end

    rd_chk: assert property (@(negedge clk_i) disable iff (!arst_n_i)
        result.valid |-> result.rd == exp_wb.rd)
    else begin
        errors++;
        $display("Mismatch at %0t: result_o.rd expected %0d got %0d",
                 $time, exp_wb.rd, result.rd);
    end

    data_chk: assert property (@(negedge clk_i) disable iff (!arst_n_i)
        result.valid |-> result.data == exp_wb.data)
    else begin
        errors++;
        $display("Mismatch at %0t: result_o.data expected %h got %h",
                 $time, exp_wb.data, result.data);
    end

    illegal_chk: assert property (@(negedge clk_i) disable iff (!arst_n_i)
        illegal_o == exp_illegal)
    else begin
        errors++;
        $display("Mismatch at %0t: illegal_o expected %b got %b",
                 $time, exp_illegal, illegal_o);
    end

    // rv32i alu rules with the shift amount from b[4:0]
    function automatic riscv_pkg::xlen_t alu_model(input logic [2:0] f3, input logic alt,
                                                   input riscv_pkg::xlen_t a,
                                                   input riscv_pkg::xlen_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? riscv_pkg::xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // one quiet cycle with no instruction and no load
    task automatic idle_cycle();
        @(posedge clk_i);
        instr_valid_i <= 1'b0;
        ld_wr_i       <= 1'b0;
        nxt_wb.valid  <= 1'b0;
        nxt_illegal   <= 1'b0;
    endtask

    // drive an instruction and update the model in program order
    task automatic issue(input riscv_pkg::instr_t ins, input logic legal,
                         input riscv_pkg::reg_addr_t rd, input riscv_pkg::xlen_t data);
        @(posedge clk_i);
        instr_valid_i <= 1'b1;
        instr_i       <= ins;
        ld_wr_i       <= 1'b0;
        nxt_wb        <= '{valid: legal, rd: rd, data: data};
        nxt_illegal   <= ~legal;
        if (legal && rd != 0) begin
            ref_regs[rd] = data;
        end
    endtask

    task automatic op_rr(input logic [2:0] f3, input logic alt,
                         input int rd, input int rs1, input int rs2);
        issue({1'b0, alt, 5'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), riscv_pkg::OPC_OP}, 1'b1,
              5'(rd), alu_model(f3, alt, ref_regs[rs1], ref_regs[rs2]));
    endtask

    // i-type where imm[10] marks srai
    task automatic op_ri(input logic [2:0] f3, input int rd, input int rs1,
                         input logic [11:0] imm);
        issue({imm, 5'(rs1), f3, 5'(rd), riscv_pkg::OPC_OP_IMM}, 1'b1, 5'(rd),
              alu_model(f3, (f3 == 3'd5) && imm[10], ref_regs[rs1], {{20{imm[11]}}, imm}));
    endtask

    task automatic lui(input int rd, input logic [19:0] imm);
        issue({imm, 5'(rd), riscv_pkg::OPC_LUI}, 1'b1, 5'(rd), {imm, 12'b0});
    endtask

    task automatic load_reg(input int rd, input riscv_pkg::xlen_t data);
        idle_cycle();
        ld_wr_i   <= 1'b1;
        ld_rd_i   <= 5'(rd);
        ld_data_i <= data;
        if (rd != 0) begin
            ref_regs[rd] = data;
        end
    endtask

    // load strobe and an add reading the same register in one cycle
    task automatic load_and_read(input int rd, input riscv_pkg::xlen_t data, input int dst);
        if (rd != 0) begin
            ref_regs[rd] = data;
        end
        op_rr(3'd0, 1'b0, dst, rd, 0);
        ld_wr_i   <= 1'b1;
        ld_rd_i   <= 5'(rd);
        ld_data_i <= data;
    endtask

    // wait mid-cycle for a valid result or an illegal pulse
    task automatic wait_result(input logic want_illegal);
        int n;
        n = 0;
        @(negedge clk_i);
        while ((want_illegal ? illegal_o : result.valid) !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (n >= TIMEOUT) begin
            errors++;
            $display("timeout: no %s within %0d cycles",
                     want_illegal ? "illegal pulse" : "valid result", TIMEOUT);
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %0d %s done, %0d errors", tests, name, errors - mark);
        mark = errors;
    endtask

    initial begin
        riscv_pkg::xlen_t r;
        riscv_pkg::xlen_t ld_val;
        arst_n_i      = 1'b0;
        clk_en_i      = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        ld_wr_i       = 1'b0;
        ld_rd_i       = '0;
        ld_data_i     = '0;
        nxt_wb        = '0;
        nxt_illegal   = 1'b0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        repeat (8) @(posedge clk_i);
        arst_n_i <= 1'b1;

        // quiet after reset and then an add of two cleared registers
        repeat (3) idle_cycle();
        op_rr(3'd0, 1'b0, 3, 1, 2);
        idle_cycle();
        wait_result(1'b0);
        report_test("reset");

        // random constants via lui and addi and then all alu ops
        for (int i = 1; i <= 4; i++) begin
            r = $random(seed);
            lui(i, r[31:12]);
            op_ri(3'd0, i, i, r[11:0]);
        end
        for (int f3 = 0; f3 < 8; f3++) begin
            op_rr(3'(f3), 1'b0, 5, 1, 2);
            r = $random(seed);
            if (f3 == 1 || f3 == 5) begin
                r[11:5] = 7'h0;
            end
            op_ri(3'(f3), 6, 3, r[11:0]);
        end
        op_rr(3'd0, 1'b1, 7, 1, 4);
        op_rr(3'd5, 1'b1, 8, 4, 2);
        r = $random(seed);
        op_ri(3'd5, 9, 4, {7'h20, r[4:0]});
        idle_cycle();
        wait_result(1'b0);
        report_test("alu");

        // dependent chain with an x0 write in the middle
        op_rr(3'd0, 1'b0, 10, 1, 2);
        op_rr(3'd0, 1'b1, 11, 10, 3);
        op_rr(3'd4, 1'b0, 12, 11, 10);
        op_ri(3'd0, 0, 12, 12'h123);
        op_rr(3'd0, 1'b0, 13, 0, 12);
        idle_cycle();
        wait_result(1'b0);
        report_test("forwarding");

        // load then read, then load, alu writeback and a reader all on x16
        ld_val = $random(seed);
        load_reg(14, ld_val);
        op_rr(3'd0, 1'b0, 15, 14, 0);
        op_ri(3'd0, 16, 1, 12'h7ff);
        load_and_read(16, ~ld_val, 21);
        op_rr(3'd6, 1'b0, 17, 16, 0);
        idle_cycle();
        wait_result(1'b0);
        report_test("load");

        // unknown opcode and then a mul encoding
        issue({25'h0, 7'b1111111}, 1'b0, 5'd0, '0);
        idle_cycle();
        wait_result(1'b1);
        issue({7'b0000001, 5'd2, 5'd1, 3'd0, 5'd18, riscv_pkg::OPC_OP}, 1'b0, 5'd0, '0);
        idle_cycle();
        wait_result(1'b1);
        report_test("illegal");

        // stalled cycles carry an instruction and a load that must not land
        op_rr(3'd0, 1'b0, 19, 1, 2);
        @(posedge clk_i);
        clk_en_i      <= 1'b0;
        instr_i       <= {12'h055, 5'd0, 3'd0, 5'd19, riscv_pkg::OPC_OP_IMM};
        ld_wr_i       <= 1'b1;
        ld_rd_i       <= 5'd14;
        ld_data_i     <= ~ld_val;
        nxt_wb.valid  <= 1'b0;
        repeat (4) @(posedge clk_i);
        idle_cycle();
        clk_en_i <= 1'b1;
        op_rr(3'd0, 1'b0, 20, 19, 14);
        idle_cycle();
        wait_result(1'b0);
        report_test("stall");

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
riscv_pkg.sv
int_regs.sv
exec_ctrl.sv
operand_bypass.sv
int_alu.sv
int_exec_top.sv
tb_int_exec.sv

/* run_sim.sh */
#!/bin/sh
# build and run the integer execute testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_int_exec -f verilog.f -o tb_int_exec
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_int_exec > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
    exit 1
fi
exit 0
